// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 -f project.f \
		--top-module tb_bitstat -Mdir obj_dir
	./obj_dir/Vtb_bitstat

clean:
	rm -rf obj_dir

// File: project.f
+incdir+src
src/bitstat_pkg.sv
src/stat_if.sv
src/parallel_counter.sv
src/min_select.sv
src/bitstat_regs.sv
src/bitstat_top.sv
test/tb_bitstat.sv

// File: src/bitstat_defines.svh
`ifndef BITSTAT_DEFINES_SVH
`define BITSTAT_DEFINES_SVH

// counted vector, fits one bus word
`define BITSTAT_VEC_W      31
// log2(31+1)
`define BITSTAT_CNT_W      5

// numbers word, eight nibbles
`define BITSTAT_NUM_COUNT  8
`define BITSTAT_NUM_W      4
`define BITSTAT_IDX_W      3

// wishbone widths
`define BITSTAT_ADR_W      4
`define BITSTAT_DAT_W      32

// register byte offsets
`define BITSTAT_REG_VEC    4'h0
`define BITSTAT_REG_NUMS   4'h4
// read-only results
`define BITSTAT_REG_COUNT  4'h8
`define BITSTAT_REG_MIN    4'hC

`endif

// File: src/bitstat_pkg.sv
`include "bitstat_defines.svh"

package bitstat_pkg;

    // operand and result vectors
    typedef logic [`BITSTAT_VEC_W-1:0] bit_vec_t;
    typedef logic [`BITSTAT_CNT_W-1:0] count_t;

    // number k in bits 4k+3 downto 4k
    typedef logic [`BITSTAT_NUM_COUNT*`BITSTAT_NUM_W-1:0] num_word_t;

    // minimum position, one-hot and encoded
    typedef logic [`BITSTAT_NUM_COUNT-1:0] min_onehot_t;
    typedef logic [`BITSTAT_IDX_W-1:0] min_index_t;

    // bus fields
    typedef logic [`BITSTAT_ADR_W-1:0] wb_adr_t;
    typedef logic [`BITSTAT_DAT_W-1:0] wb_dat_t;

    // slave handshake states
    // ack lasts exactly one cycle
    typedef enum logic {
        idle,
        ack
    } bus_state_t;

endpackage

// File: src/bitstat_regs.sv
`timescale 1ns/1ps

`include "bitstat_defines.svh"

module bitstat_regs
    import bitstat_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    wb_cyc,
    input  logic    wb_stb,
    input  logic    wb_we,
    input  wb_adr_t wb_adr,
    input  wb_dat_t wb_wdata,
    output wb_dat_t wb_rdata,
    output logic    wb_ack,
    stat_if.regs    stat
);

    bus_state_t state;
    bit_vec_t   vec_reg;
    num_word_t  nums_reg;
    wb_adr_t    reg_off;
    wb_dat_t    rd_next;
    logic       req;
    logic       take;
    logic       at_most_one;

    // word access only, byte lanes dropped
    assign reg_off = wb_adr & wb_adr_t'(4'hC);
    assign req     = wb_cyc && wb_stb;
    // request accepted only from idle
    assign take    = req && (state == idle);

    // single-bit check from the popcount
    assign at_most_one = (stat.count <= count_t'(1));

    // idle/ack handshake
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (req) begin
                        state <= ack;
                    end
                end
                // back to idle, held strobe waits one edge
                ack: state <= idle;
                default: state <= idle;
            endcase
        end
    end

    assign wb_ack = (state == ack);

    // operand registers, written on the ack-raising edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vec_reg  <= '0;
            nums_reg <= '0;
        end else if (take && wb_we) begin
            case (reg_off)
                `BITSTAT_REG_VEC:  vec_reg  <= wb_wdata[`BITSTAT_VEC_W-1:0];
                `BITSTAT_REG_NUMS: nums_reg <= wb_wdata;
                // result registers ignore writes
                default: ;
            endcase
        end
    end

    // read mux
    always_comb begin
        case (reg_off)
            `BITSTAT_REG_VEC:   rd_next = wb_dat_t'(vec_reg);
            `BITSTAT_REG_NUMS:  rd_next = nums_reg;
            // count in 4..0, flag in 8
            `BITSTAT_REG_COUNT: rd_next = wb_dat_t'({at_most_one, 3'b000, stat.count});
            // one-hot in 7..0, index in 18..16
            `BITSTAT_REG_MIN:   rd_next = wb_dat_t'({stat.min_index, 8'h00, stat.min_onehot});
            default:            rd_next = '0;
        endcase
    end

    // read data held until the next read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_rdata <= '0;
        end else if (take && !wb_we) begin
            wb_rdata <= rd_next;
        end
    end

    assign stat.vec  = vec_reg;
    assign stat.nums = nums_reg;

    // one-cycle ack pulse
    a_ack_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        wb_ack |=> !wb_ack);

    // no ack without a preceding request
    a_ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(wb_ack) |-> $past(req));

endmodule

// File: src/bitstat_top.sv
`timescale 1ns/1ps

`include "bitstat_defines.svh"

module bitstat_top
    import bitstat_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    wb_cyc,
    input  logic    wb_stb,
    input  logic    wb_we,
    input  wb_adr_t wb_adr,
    input  wb_dat_t wb_wdata,
    output wb_dat_t wb_rdata,
    output logic    wb_ack
);

    // operands out, results back
    stat_if i_stat ();

    // bus slave and operand registers
    bitstat_regs i_regs (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack),
        .stat     (i_stat.regs)
    );

    // popcount of the vector
    parallel_counter i_counter (
        .stat (i_stat.counter)
    );

    // smallest nibble, lowest index on ties
    min_select i_min (
        .stat (i_stat.minimum)
    );

endmodule

// File: src/min_select.sv
`timescale 1ns/1ps

`include "bitstat_defines.svh"

// and-or mux, sel must be one-hot
module one_hot_mux #(
    parameter int IN_W  = 24,
    parameter int SEL_W = 8,
    parameter int OUT_W = IN_W / SEL_W
) (
    input  logic [IN_W-1:0]  mux_in,
    input  logic [SEL_W-1:0] sel,
    output logic [OUT_W-1:0] mux_out
);

    logic [SEL_W-1:0] col [OUT_W];

    for (genvar i = 0; i < OUT_W; i++) begin : g_out
        for (genvar j = 0; j < SEL_W; j++) begin : g_sel
            // slice j masked by its select bit
            assign col[i][j] = mux_in[j*OUT_W + i] & sel[j];
        end
        assign mux_out[i] = |col[i];
    end

endmodule

module one_hot_to_bin #(
    parameter int ONE_HOT_W = 8,
    parameter int BIN_W     = $clog2(ONE_HOT_W)
) (
    input  logic [ONE_HOT_W-1:0] one_hot_code,
    output logic [BIN_W-1:0]     bin_code
);

    logic [ONE_HOT_W*BIN_W-1:0] index_table;

    // slice i holds the constant i
    for (genvar i = 0; i < ONE_HOT_W; i++) begin : g_const
        assign index_table[i*BIN_W +: BIN_W] = BIN_W'(i);
    end

    one_hot_mux #(
        .IN_W  (ONE_HOT_W * BIN_W),
        .SEL_W (ONE_HOT_W)
    ) i_mux (
        .mux_in  (index_table),
        .sel     (one_hot_code),
        .mux_out (bin_code)
    );

endmodule

module min_select
    import bitstat_pkg::*;
(
    stat_if.minimum stat
);

    logic [`BITSTAT_NUM_W-1:0]     num  [`BITSTAT_NUM_COUNT];
    logic [`BITSTAT_NUM_COUNT-1:0] wins [`BITSTAT_NUM_COUNT];
    min_onehot_t                   onehot;
    min_index_t                    index;

    for (genvar i = 0; i < `BITSTAT_NUM_COUNT; i++) begin : g_num
        assign num[i] = stat.nums[i*`BITSTAT_NUM_W +: `BITSTAT_NUM_W];
    end

    // row i, does number i beat every other one
    for (genvar i = 0; i < `BITSTAT_NUM_COUNT; i++) begin : g_row
        for (genvar j = 0; j < `BITSTAT_NUM_COUNT; j++) begin : g_col
            if (j > i) begin : g_hi
                // ties against higher indices go to i
                assign wins[i][j] = (num[i] <= num[j]);
            end else if (j < i) begin : g_lo
                assign wins[i][j] = (num[i] < num[j]);
            end else begin : g_self
                assign wins[i][j] = 1'b1;
            end
        end
        assign onehot[i] = &wins[i];
    end

    one_hot_to_bin #(
        .ONE_HOT_W (`BITSTAT_NUM_COUNT),
        .BIN_W     (`BITSTAT_IDX_W)
    ) i_enc (
        .one_hot_code (onehot),
        .bin_code     (index)
    );

    assign stat.min_onehot = onehot;
    assign stat.min_index  = index;

    // exactly one winner, else the encoder ORs indices together
    a_min_onehot: assert property (@(stat.min_onehot)
        $isunknown(stat.min_onehot) || $onehot(stat.min_onehot));

endmodule

// File: src/parallel_counter.sv
`timescale 1ns/1ps

`include "bitstat_defines.svh"

// seven bits in
// one sum bit plus three carries of weight two
// low four bits and high three bits counted apart
module cs_gen (
    input  logic [6:0] din,
    output logic [2:0] abc,
    output logic       s
);

    logic [3:0] grp_lo;
    logic [2:0] grp_hi;
    logic [2:0] cnt_lo;
    logic [1:0] cnt_hi;
    logic       a;
    logic       b;
    logic       c;

    assign {grp_hi, grp_lo} = din;

    // small group counts
    assign cnt_lo = 3'(grp_lo[0]) + 3'(grp_lo[1]) + 3'(grp_lo[2]) + 3'(grp_lo[3]);
    assign cnt_hi = 2'(grp_hi[0]) + 2'(grp_hi[1]) + 2'(grp_hi[2]);

    // parity of the whole group
    assign s = cnt_lo[0] ^ cnt_hi[0];
    // two or more in the low group
    assign a = (cnt_lo > 3'd1);
    // two or more in the high group
    assign b = (cnt_hi > 2'd1);
    // all four low set or both groups odd
    assign c = (cnt_lo == 3'd4) | (cnt_lo[0] & cnt_hi[0]);

    assign abc = {a, b, c};

endmodule

module pc_7_3 (
    input  logic [6:0] din,
    output logic [2:0] dout
);

    logic [2:0] abc;

    cs_gen i_cs (
        .din (din),
        .abc (abc),
        .s   (dout[0])
    );

    // carries have weight two
    assign dout[2:1] = 2'(abc[0]) + 2'(abc[1]) + 2'(abc[2]);

endmodule

module pc_15_4 (
    input  logic [14:0] din,
    output logic [3:0]  dout
);

    logic [2:0] abc0;
    logic [2:0] abc1;
    logic       s0;
    logic       s1;
    logic       b2;

    cs_gen i_cs0 (
        .din (din[6:0]),
        .abc (abc0),
        .s   (s0)
    );

    cs_gen i_cs1 (
        .din (din[13:7]),
        .abc (abc1),
        .s   (s1)
    );

    // leftover bit joins both sum bits
    // its carry goes up with the others
    assign {b2, dout[0]} = 2'(din[14]) + 2'(s0) + 2'(s1);

    pc_7_3 i_pc_sub (
        .din  ({abc0, abc1, b2}),
        .dout (dout[3:1])
    );

endmodule

module pc_31_5 (
    input  logic [30:0] din,
    output logic [4:0]  dout
);

    localparam int CS_NUM = 4;

    logic [CS_NUM-1:0] s;
    logic [14:0]       pc_15_in;

    // first row over the low 28 bits
    for (genvar i = 0; i < CS_NUM; i++) begin : g_cs
        cs_gen i_cs (
            .din (din[i*7 +: 7]),
            .abc (pc_15_in[i*3 +: 3]),
            .s   (s[i])
        );
    end

    // first four sum bits fill the last generator
    cs_gen i_cs_last (
        .din ({s, din[30:28]}),
        .abc (pc_15_in[14:12]),
        .s   (dout[0])
    );

    // fifteen carries of weight two
    pc_15_4 i_pc_15 (
        .din  (pc_15_in),
        .dout (dout[4:1])
    );

endmodule

module parallel_counter
    import bitstat_pkg::*;
(
    stat_if.counter stat
);

    count_t count;

    // full tree over the fixed 31-bit vector
    pc_31_5 i_pc_31 (
        .din  (stat.vec),
        .dout (count)
    );

    assign stat.count = count;

    // tree result matches the ones in the vector
    a_count_ones: assert property (@(stat.count)
        $isunknown(stat.vec) || (stat.count == count_t'($countones(stat.vec))));

endmodule

// File: src/stat_if.sv
`timescale 1ns/1ps

`include "bitstat_defines.svh"

interface stat_if
    import bitstat_pkg::*;
();

    // operands from the register block
    bit_vec_t    vec;
    num_word_t   nums;

    // results, combinational from the operands
    count_t      count;
    min_onehot_t min_onehot;
    min_index_t  min_index;

    // register side owns the operands
    modport regs (
        output vec,
        output nums,
        input  count,
        input  min_onehot,
        input  min_index
    );

    // popcount tree
    modport counter (
        input  vec,
        output count
    );

    // minimum finder and encoder
    modport minimum (
        input  nums,
        output min_onehot,
        output min_index
    );

endinterface

// File: test/tb_bitstat.sv
`timescale 1ns/1ps

`include "bitstat_defines.svh"

module tb_bitstat
    import bitstat_pkg::*;
();

    localparam int N_FIXED     = 12;
    localparam int N_RANDOM    = 16;
    localparam int N_ENTRIES   = N_FIXED + N_RANDOM;
    // 40 cycles per entry, one extra slot for the reset reads, reset and margin
    localparam int CYCLE_LIMIT = 40 * (N_ENTRIES + 1) + 16 + 64;

    logic    clk = 1'b0;
    logic    arst_n;
    logic    wb_cyc;
    logic    wb_stb;
    logic    wb_we;
    wb_adr_t wb_adr;
    wb_dat_t wb_wdata;
    wb_dat_t wb_rdata;
    logic    wb_ack;
    int      cycles = 0;

    // stimulus and expected results
    bit_vec_t  tab_vec  [N_ENTRIES];
    num_word_t tab_nums [N_ENTRIES];
    int        tab_cnt  [N_ENTRIES];
    int        tab_idx  [N_ENTRIES];

    bitstat_top i_bitstat_top (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // reference popcount
    function automatic int count_ones(input bit_vec_t v);
        int n;
        n = 0;
        for (int b = 0; b < `BITSTAT_VEC_W; b++) begin
            n = n + int'(v[b]);
        end
        return n;
    endfunction

    // lowest index of the smallest nibble, strict compare keeps the earlier one
    function automatic int min_position(input num_word_t w);
        int best;
        best = 0;
        for (int k = 1; k < `BITSTAT_NUM_COUNT; k++) begin
            if (w[4*k +: 4] < w[4*best +: 4]) begin
                best = k;
            end
        end
        return best;
    endfunction

    task automatic set_entry(input int i, input bit_vec_t vec, input num_word_t nums,
                             input int cnt, input int idx);
        tab_vec[i]  = vec;
        tab_nums[i] = nums;
        tab_cnt[i]  = cnt;
        tab_idx[i]  = idx;
    endtask

    // one classic cycle, ack latency and ack pulse width checked on the way
    task automatic bus_access(input logic we, input wb_adr_t adr, input wb_dat_t wdata,
                              input string name, output wb_dat_t rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_wdata <= wdata;
        // sample between edges, give up after a few cycles
        do begin
            @(posedge clk);
            waited++;
            @(negedge clk);
        end while (!wb_ack && waited < 8);
        check_value({name, " ack latency"}, 32'd1, 32'(waited));
        rdata = wb_rdata;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        check_value({name, " ack width"}, 32'd0, 32'(wb_ack));
    endtask

    task automatic wb_write(input wb_adr_t adr, input wb_dat_t data, input string name);
        wb_dat_t unused;
        bus_access(1'b1, adr, data, name, unused);
    endtask

    task automatic wb_read(input wb_adr_t adr, input string name, output wb_dat_t data);
        bus_access(1'b0, adr, '0, name, data);
    endtask

    // reads all four registers against expected operands and results
    task automatic read_all(input string tag, input bit_vec_t vec, input num_word_t nums,
                            input int cnt, input int idx);
        wb_dat_t data;
        wb_dat_t exp_count;
        wb_dat_t exp_min;
        // flag at bit 8, count in 4..0
        exp_count = ((cnt <= 1) ? 32'h100 : 32'h0) | 32'(cnt);
        // index in 18..16, one-hot in 7..0
        exp_min   = (32'(idx) << 16) | (32'h1 << idx);
        wb_read(`BITSTAT_REG_VEC, {tag, " vec"}, data);
        check_value({tag, " vec"}, {1'b0, vec}, data);
        wb_read(`BITSTAT_REG_NUMS, {tag, " nums"}, data);
        check_value({tag, " nums"}, nums, data);
        wb_read(`BITSTAT_REG_COUNT, {tag, " count"}, data);
        check_value({tag, " count"}, exp_count, data);
        wb_read(`BITSTAT_REG_MIN, {tag, " min"}, data);
        check_value({tag, " min"}, exp_min, data);
    endtask

    initial begin
        string tag;
        void'($urandom(81));
        arst_n   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_wdata = '0;

        // fixed entries, expected values worked out by hand
        set_entry(0,  31'h0000_0000, 32'h0000_0000, 0,  0);
        set_entry(1,  31'h0000_0001, 32'h7654_3210, 1,  0);
        set_entry(2,  31'h4000_0000, 32'h0123_4567, 1,  7);
        set_entry(3,  31'h7FFF_FFFF, 32'hFFFF_FFFF, 31, 0);
        set_entry(4,  31'h5555_5555, 32'h9999_3999, 16, 3);
        set_entry(5,  31'h2AAA_AAAA, 32'h5A5A_5A5A, 15, 1);
        set_entry(6,  31'h0000_0003, 32'h2222_2222, 2,  0);
        // tie on 1 at nibbles 4, 5 and 7
        set_entry(7,  31'h0001_0000, 32'h1811_8888, 1,  4);
        set_entry(8,  31'h7FFF_FFFE, 32'h0FFF_FFFF, 30, 7);
        set_entry(9,  31'h0F0F_0F0F, 32'hEDCB_A98F, 16, 1);
        // tie on 3 at nibbles 1 and 7
        set_entry(10, 31'h1234_5678, 32'h3444_4434, 13, 1);
        set_entry(11, 31'h4000_0001, 32'h6600_6666, 2,  4);

        // random entries scored by the model
        for (int i = N_FIXED; i < N_ENTRIES; i++) begin
            tab_vec[i]  = 31'($urandom());
            tab_nums[i] = $urandom();
            tab_cnt[i]  = count_ones(tab_vec[i]);
            tab_idx[i]  = min_position(tab_nums[i]);
        end

        repeat (16) @(posedge clk);
        arst_n <= 1'b1;

        // reset values, all-zero operands
        read_all("reset", '0, '0, 0, 0);

        for (int i = 0; i < N_ENTRIES; i++) begin
            tag = $sformatf("entry %0d", i);
            // bit 31 toggles with the data, must not stick
            wb_write(`BITSTAT_REG_VEC, {~tab_vec[i][0], tab_vec[i]}, {tag, " wr vec"});
            wb_write(`BITSTAT_REG_NUMS, tab_nums[i], {tag, " wr nums"});
            // result registers are read-only
            wb_write(`BITSTAT_REG_COUNT, 32'hFFFF_FFFF, {tag, " wr count"});
            wb_write(`BITSTAT_REG_MIN, 32'hFFFF_FFFF, {tag, " wr min"});
            read_all(tag, tab_vec[i], tab_nums[i], tab_cnt[i], tab_idx[i]);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
